// ==== files.f ====
source/psx_loader_pkg.sv
source/download_decoder.sv
source/ram_download_writer.sv
source/media_tracker.sv
source/psx_loader_top.sv
test/tb_psx_loader.sv

// ==== test/tb_psx_loader.sv ====
// Directed testbench for the loader and media bookkeeping top level.
// A behavioral RAM answers each write request after 1 to 8 cycles.
// Host halves are sent only while ioctl_wait is low.
// Every wait is bounded and a timeout counts as a failed check.
// Outputs are read right after the rising edge, before that edge's updates.

module tb_psx_loader
	import psx_loader_pkg::*;
();

	logic                        clk_1x;
	logic                        rst_n;
	logic                        ioctl_download;
	logic [7:0]                  ioctl_index;
	logic [IOCTL_ADDR_W-1:0]     ioctl_addr;
	logic [IOCTL_DATA_W-1:0]     ioctl_dout;
	logic                        ioctl_wr;
	logic                        ioctl_wait;
	logic                        ram_wr_req;
	logic [RAM_ADDR_W-1:0]       ram_wr_addr;
	logic [RAM_DATA_W-1:0]       ram_wr_data;
	logic [RAM_BE_W-1:0]         ram_wr_be;
	logic                        ram_wr_ack;
	logic                        core_wr_req;
	logic [RAM_ADDR_W-1:0]       core_wr_addr;
	logic [RAM_DATA_W-1:0]       core_wr_data;
	logic [RAM_BE_W-1:0]         core_wr_be;
	logic                        core_wr_ack;
	logic [2:0]                  img_mounted;
	logic [IMG_SIZE_W-1:0]       img_size;
	logic                        user_reset;
	logic                        memcard_reload;
	logic                        memcard_save_cmd;
	logic                        autosave_en;
	logic                        osd_open;
	logic                        exe_loaded;
	logic                        core_reset;
	logic                        trackinfo_write;
	logic [TRACKINFO_ADDR_W-1:0] trackinfo_addr;
	logic [RAM_DATA_W-1:0]       trackinfo_data;
	logic                        has_cd;
	logic                        new_cd;
	logic                        cd_from_sd;
	logic [CD_SIZE_W-1:0]        cd_size;
	logic [IOCTL_DATA_W-1:0]     libcrypt_key;
	logic                        card1_mounted;
	logic                        card2_mounted;
	logic                        card1_load;
	logic                        card2_load;
	logic                        card_save;
	logic                        media_loaded;

	// RAM model state
	integer                seed = 32'hd989c4b9;
	int                    ack_count = 0;
	logic [RAM_ADDR_W-1:0] log_addr[$];
	logic [RAM_DATA_W-1:0] log_data[$];
	logic [RAM_BE_W-1:0]   log_be[$];

	// Bookkeeping
	string test_name;
	int    test_errors = 0;
	int    error_count = 0;
	int    tests_run = 0;
	int    tests_failed = 0;
	int    wait_high_cycles = 0;
	int    n_new_cd;
	int    n_card1_load;
	int    n_card2_load;
	int    n_card_save;

	psx_loader_top dut_i (.*);

	initial begin
		clk_1x = 1'b0;
		forever #50 clk_1x = ~clk_1x;
	end

	always @(posedge clk_1x)
		if (ioctl_wait === 1'b1)
			wait_high_cycles++;

	// ========================================
	// RAM acknowledge model
	// ========================================

	initial begin : ram_model
		int delay;
		ram_wr_ack = 1'b0;
		forever begin
			@(posedge clk_1x);
			if (ram_wr_req === 1'b1) begin
				log_addr.push_back(ram_wr_addr);
				log_data.push_back(ram_wr_data);
				log_be.push_back(ram_wr_be);
				delay = 1 + ($unsigned($random(seed)) % 8);
				repeat (delay - 1) @(posedge clk_1x);
				ram_wr_ack <= 1'b1;
				ack_count++;
				@(posedge clk_1x);
				ram_wr_ack <= 1'b0;
			end
		end
	end

	// ========================================
	// Reporting
	// ========================================

	task automatic report_mismatch(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("ERROR %s %s: expected 'h%0h, actual 'h%0h", test_name, what, expected, actual);
		test_errors++;
	endtask

	task automatic report_failure(input string what);
		$display("%s: %s", test_name, what);
		test_errors++;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		error_count += test_errors;
		if (test_errors == 0) begin
			$display("test %s passed", test_name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", test_name, test_errors);
		end
	endtask

	// ========================================
	// Stimulus helpers
	// ========================================

	task automatic apply_reset();
		@(posedge clk_1x);
		rst_n <= 1'b0;
		repeat (16) @(posedge clk_1x);
		rst_n <= 1'b1;
		@(posedge clk_1x);
	endtask

	task automatic start_download(input logic [7:0] index);
		@(posedge clk_1x);
		ioctl_index    <= index;
		ioctl_download <= 1'b1;
		// Kind flags are registered
		repeat (2) @(posedge clk_1x);
	endtask

	task automatic end_download();
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
	endtask

	task automatic send_half(input logic [IOCTL_ADDR_W-1:0] addr,
		input logic [IOCTL_DATA_W-1:0] data);
		@(posedge clk_1x);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_1x);
		ioctl_wr <= 1'b0;
	endtask

	task automatic mount_image(input logic [2:0] slots, input logic [IMG_SIZE_W-1:0] size);
		@(posedge clk_1x);
		img_mounted <= slots;
		img_size    <= size;
		@(posedge clk_1x);
		img_mounted <= 3'b000;
	endtask

	// Counts every pulse output over a window
	task automatic watch_pulses(input int cycles);
		n_new_cd = 0;
		n_card1_load = 0;
		n_card2_load = 0;
		n_card_save = 0;
		repeat (cycles) begin
			@(posedge clk_1x);
			if (new_cd === 1'b1)
				n_new_cd++;
			if (card1_load === 1'b1)
				n_card1_load++;
			if (card2_load === 1'b1)
				n_card2_load++;
			if (card_save === 1'b1)
				n_card_save++;
		end
	endtask

	task automatic check_ram_write(input logic [RAM_ADDR_W-1:0] addr,
		input logic [RAM_DATA_W-1:0] data, input logic [RAM_BE_W-1:0] be);
		if (log_addr.size() == 0) begin
			report_failure("no write reached the RAM");
		end else begin
			if (log_addr[0] !== addr)
				report_mismatch("RAM address", addr, log_addr[0]);
			if (log_data[0] !== data)
				report_mismatch("RAM data", data, log_data[0]);
			if (log_be[0] !== be)
				report_mismatch("RAM byte enables", be, log_be[0]);
			void'(log_addr.pop_front());
			void'(log_data.pop_front());
			void'(log_be.pop_front());
		end
	endtask

	// One word to RAM, low half first, then wait for the host release
	task automatic send_word(input logic [IOCTL_ADDR_W-1:0] addr,
		input logic [RAM_DATA_W-1:0] word, input logic [RAM_ADDR_W-1:0] base);
		int acks;
		int cycles;
		acks = ack_count;
		send_half(addr, word[15:0]);
		send_half(addr + 27'd2, word[31:16]);
		@(posedge clk_1x);
		if (ram_wr_req !== 1'b1)
			report_failure("no RAM write request after the high half");
		if (ioctl_wait !== 1'b1)
			report_failure("host wait line did not rise with the request");
		cycles = 0;
		while (ioctl_wait !== 1'b0 && cycles < 20) begin
			@(posedge clk_1x);
			cycles++;
		end
		if (ioctl_wait !== 1'b0)
			report_failure("timed out waiting for the host wait line to fall");
		else if (ack_count == acks)
			report_failure("host wait line fell before the RAM ack");
		check_ram_write(base + addr, word, {RAM_BE_W{1'b1}});
	endtask

	// ========================================
	// Tests
	// ========================================

	task automatic test_reset_state();
		logic [11:0] flags;
		begin_test("reset_state");
		flags = {ioctl_wait, ram_wr_req, core_reset, exe_loaded, has_cd, new_cd,
			card1_mounted, card2_mounted, card1_load, card2_load, card_save, media_loaded};
		if (flags !== 12'h000)
			report_mismatch("status after reset", 12'h000, flags);
		end_test();
	endtask

	task automatic test_bios_download();
		begin_test("bios_download");
		start_download(INDEX_BIOS);
		for (int i = 0; i < 4; i++)
			send_word(27'h100 + 27'(i * 4), 32'hc0de_0000 + 32'(i) * 32'h0011_0101, BIOS_START);
		end_download();
		end_test();
	endtask

	task automatic test_exe_download();
		int pulses;
		int pulse_cycle;
		begin_test("exe_download");
		start_download(INDEX_EXE);
		for (int i = 0; i < 3; i++)
			send_word(27'h800 + 27'(i * 4), 32'h5eed_a000 ^ (32'(i) << 20), EXE_START);
		if (core_reset !== 1'b1)
			report_mismatch("core_reset during download", 1'b1, core_reset);
		end_download();
		pulses = 0;
		pulse_cycle = -1;
		// Cycle 0 is the first one with ioctl_download low
		for (int k = 1; k <= 8; k++) begin
			@(posedge clk_1x);
			if (exe_loaded === 1'b1) begin
				pulses++;
				pulse_cycle = k - 1;
			end
		end
		if (pulses != 1)
			report_mismatch("exe_loaded pulses", 1, pulses);
		if (pulse_cycle != 2)
			report_mismatch("exe_loaded cycle", 2, pulse_cycle);
		if (core_reset !== 1'b0)
			report_mismatch("core_reset after download", 1'b0, core_reset);
		end_test();
	endtask

	task automatic test_core_writes();
		logic [RAM_ADDR_W-1:0] addr;
		logic [RAM_DATA_W-1:0] data;
		logic [RAM_BE_W-1:0]   be;
		int                    cycles;
		begin_test("core_writes");
		for (int i = 0; i < 3; i++) begin
			addr = 27'h012_3400 + 27'(i * 8);
			data = 32'h0bad_f00d + 32'(i) * 32'h1111_0000;
			be   = 4'b0011 << i;
			@(posedge clk_1x);
			core_wr_req  <= 1'b1;
			core_wr_addr <= addr;
			core_wr_data <= data;
			core_wr_be   <= be;
			@(posedge clk_1x);
			core_wr_req <= 1'b0;
			if (ram_wr_req !== 1'b1)
				report_failure("core request did not reach the RAM channel");
			cycles = 0;
			while (core_wr_ack !== 1'b1 && cycles < 20) begin
				@(posedge clk_1x);
				cycles++;
				if (ioctl_wait !== 1'b0)
					report_failure("core write raised the host wait line");
			end
			if (core_wr_ack !== 1'b1)
				report_failure("timed out waiting for the core ack");
			check_ram_write(addr, data, be);
		end
		end_test();
	endtask

	task automatic test_trackinfo_and_key();
		logic [IOCTL_ADDR_W-1:0] addr;
		logic [RAM_DATA_W-1:0]   word;
		int                      waits;
		int                      writes;
		begin_test("trackinfo_and_key");
		waits = wait_high_cycles;
		writes = log_addr.size();
		start_download(INDEX_CDINFO);
		// Last word crosses bit 10 of the byte address
		for (int i = 0; i < 3; i++) begin
			addr = 27'h7f8 + 27'(i * 4);
			word = 32'h7ac0_0001 + 32'(i) * 32'h0101_0010;
			send_half(addr, word[15:0]);
			send_half(addr + 27'd2, word[31:16]);
			@(posedge clk_1x);
			if (trackinfo_write !== 1'b1)
				report_failure("no track-info write after the high half");
			if (trackinfo_addr !== addr[10:2])
				report_mismatch("trackinfo_addr", addr[10:2], trackinfo_addr);
			if (trackinfo_data !== word)
				report_mismatch("trackinfo_data", word, trackinfo_data);
		end
		end_download();
		repeat (4) @(posedge clk_1x);
		if (wait_high_cycles != waits)
			report_failure("host wait line rose during a track-info download");
		if (log_addr.size() != writes)
			report_failure("track-info download wrote to RAM");

		start_download(INDEX_SBI);
		send_half(27'h0, 16'h5a3c);
		@(posedge clk_1x);
		if (libcrypt_key !== 16'h5a3c)
			report_mismatch("libcrypt_key", 16'h5a3c, libcrypt_key);
		end_download();
		end_test();
	endtask

	task automatic download_cd(input logic [7:0] index, input logic [IOCTL_ADDR_W-1:0] last);
		start_download(index);
		send_half(last - 27'd2, 16'h1111);
		send_half(last, 16'h2222);
		end_download();
	endtask

	task automatic wait_for_cd(input logic [IOCTL_ADDR_W-1:0] last);
		logic [CD_SIZE_W-1:0] exp_size;
		int                   cycles;
		exp_size = last;
		cycles = 0;
		while (has_cd !== 1'b1 && cycles < 20) begin
			@(posedge clk_1x);
			cycles++;
		end
		if (has_cd !== 1'b1)
			report_failure("timed out waiting for has_cd after a CD download");
		if (cd_size !== exp_size)
			report_mismatch("cd_size after download", exp_size, cd_size);
		if (cd_from_sd !== 1'b0)
			report_mismatch("cd_from_sd after download", 1'b0, cd_from_sd);
		if (media_loaded !== 1'b1)
			report_mismatch("media_loaded after download", 1'b1, media_loaded);
	endtask

	task automatic test_cd_tracking();
		logic [IMG_SIZE_W-1:0] size;
		begin_test("cd_tracking");
		size = 64'h0000_0001_f456_789a;

		// Empty mount still counts as media activity
		apply_reset();
		mount_image(3'b001, 64'd0);
		watch_pulses(3);
		if (media_loaded !== 1'b1)
			report_mismatch("media_loaded after empty mount", 1'b1, media_loaded);
		if (has_cd !== 1'b0)
			report_mismatch("has_cd after empty mount", 1'b0, has_cd);

		apply_reset();
		download_cd(INDEX_CD, 27'h2a_bcd6);
		wait_for_cd(27'h2a_bcd6);

		mount_image(3'b001, size);
		watch_pulses(4);
		if (n_new_cd != 1)
			report_mismatch("new_cd pulses", 1, n_new_cd);
		if (has_cd !== 1'b1)
			report_mismatch("has_cd after mount", 1'b1, has_cd);
		if (cd_from_sd !== 1'b1)
			report_mismatch("cd_from_sd after mount", 1'b1, cd_from_sd);
		if (cd_size !== size[CD_SIZE_W-1:0])
			report_mismatch("cd_size after mount", size[CD_SIZE_W-1:0], cd_size);

		mount_image(3'b001, 64'd0);
		watch_pulses(3);
		if (has_cd !== 1'b0)
			report_mismatch("has_cd after removal", 1'b0, has_cd);

		// Drive number in the upper index bits
		download_cd(INDEX_CD | 8'h40, 27'h13_5790);
		wait_for_cd(27'h13_5790);
		end_test();
	endtask

	task automatic test_memory_cards();
		begin_test("memory_cards");
		mount_image(3'b010, 64'd131072);
		watch_pulses(4);
		if (n_card1_load != 1 || n_card2_load != 0)
			report_mismatch("loads after card 1 mount", 2'b10, {n_card1_load[0], n_card2_load[0]});
		if (card1_mounted !== 1'b1)
			report_mismatch("card1_mounted", 1'b1, card1_mounted);

		mount_image(3'b100, 64'd131072);
		watch_pulses(4);
		if (n_card1_load != 0 || n_card2_load != 1)
			report_mismatch("loads after card 2 mount", 2'b01, {n_card1_load[0], n_card2_load[0]});
		if (card2_mounted !== 1'b1)
			report_mismatch("card2_mounted", 1'b1, card2_mounted);

		@(posedge clk_1x);
		memcard_reload <= 1'b1;
		watch_pulses(4);
		memcard_reload <= 1'b0;
		if (n_card1_load != 1 || n_card2_load != 1)
			report_mismatch("loads after reload", 2'b11, {n_card1_load[0], n_card2_load[0]});

		@(posedge clk_1x);
		memcard_save_cmd <= 1'b1;
		watch_pulses(4);
		memcard_save_cmd <= 1'b0;
		if (n_card_save != 1)
			report_mismatch("card_save pulses after save command", 1, n_card_save);

		// Autosave fires when the menu opens
		@(posedge clk_1x);
		autosave_en <= 1'b1;
		watch_pulses(2);
		osd_open <= 1'b1;
		watch_pulses(4);
		osd_open    <= 1'b0;
		autosave_en <= 1'b0;
		if (n_card_save != 1)
			report_mismatch("card_save pulses after autosave", 1, n_card_save);
		end_test();
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		rst_n            = 1'b0;
		ioctl_download   = 1'b0;
		ioctl_index      = 8'h00;
		ioctl_addr       = '0;
		ioctl_dout       = '0;
		ioctl_wr         = 1'b0;
		core_wr_req      = 1'b0;
		core_wr_addr     = '0;
		core_wr_data     = '0;
		core_wr_be       = '0;
		img_mounted      = 3'b000;
		img_size         = '0;
		user_reset       = 1'b0;
		memcard_reload   = 1'b0;
		memcard_save_cmd = 1'b0;
		autosave_en      = 1'b0;
		osd_open         = 1'b0;

		apply_reset();
		test_reset_state();
		test_bios_download();
		test_exe_download();
		test_core_writes();
		test_trackinfo_and_key();
		test_cd_tracking();
		test_memory_cards();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== source/psx_loader_top.sv ====
// Loader and media bookkeeping for the console core.
// The host side follows the download port protocol with ioctl_wait.
// The RAM write channel takes one request at a time, each closed by an ack.
// Core writes are only served while no BIOS or EXE download is running.

module psx_loader_top
	import psx_loader_pkg::*;
(
	input  logic                        clk_1x,
	input  logic                        rst_n,
	// Host download port
	input  logic                        ioctl_download,
	input  logic [7:0]                  ioctl_index,
	input  logic [IOCTL_ADDR_W-1:0]     ioctl_addr,
	input  logic [IOCTL_DATA_W-1:0]     ioctl_dout,
	input  logic                        ioctl_wr,
	output logic                        ioctl_wait,
	// RAM write channel
	output logic                        ram_wr_req,
	output logic [RAM_ADDR_W-1:0]       ram_wr_addr,
	output logic [RAM_DATA_W-1:0]       ram_wr_data,
	output logic [RAM_BE_W-1:0]         ram_wr_be,
	input  logic                        ram_wr_ack,
	// Core write port
	input  logic                        core_wr_req,
	input  logic [RAM_ADDR_W-1:0]       core_wr_addr,
	input  logic [RAM_DATA_W-1:0]       core_wr_data,
	input  logic [RAM_BE_W-1:0]         core_wr_be,
	output logic                        core_wr_ack,
	// Image mounts and menu
	input  logic [2:0]                  img_mounted,
	input  logic [IMG_SIZE_W-1:0]       img_size,
	input  logic                        user_reset,
	input  logic                        memcard_reload,
	input  logic                        memcard_save_cmd,
	input  logic                        autosave_en,
	input  logic                        osd_open,
	// To the core
	output logic                        exe_loaded,
	output logic                        core_reset,
	output logic                        trackinfo_write,
	output logic [TRACKINFO_ADDR_W-1:0] trackinfo_addr,
	output logic [RAM_DATA_W-1:0]       trackinfo_data,
	output logic                        has_cd,
	output logic                        new_cd,
	output logic                        cd_from_sd,
	output logic [CD_SIZE_W-1:0]        cd_size,
	output logic [IOCTL_DATA_W-1:0]     libcrypt_key,
	output logic                        card1_mounted,
	output logic                        card2_mounted,
	output logic                        card1_load,
	output logic                        card2_load,
	output logic                        card_save,
	output logic                        media_loaded
);

	// Download kinds
	logic dl_bios;
	logic dl_exe;
	logic dl_cd;
	logic dl_sbi;
	logic dl_cdinfo;
	logic cd_download_done;

	// ========================================
	// ROM detect
	// ========================================

	download_decoder decoder_i (
		.clk_1x           (clk_1x),
		.rst_n            (rst_n),
		.ioctl_download   (ioctl_download),
		.ioctl_index      (ioctl_index),
		.user_reset       (user_reset),
		.dl_bios          (dl_bios),
		.dl_exe           (dl_exe),
		.dl_cd            (dl_cd),
		.dl_sbi           (dl_sbi),
		.dl_cdinfo        (dl_cdinfo),
		.exe_loaded       (exe_loaded),
		.cd_download_done (cd_download_done),
		.core_reset       (core_reset)
	);

	// ========================================
	// Download packing and RAM sharing
	// ========================================

	ram_download_writer writer_i (
		.clk_1x          (clk_1x),
		.rst_n           (rst_n),
		.dl_bios         (dl_bios),
		.dl_exe          (dl_exe),
		.dl_cdinfo       (dl_cdinfo),
		.ioctl_addr      (ioctl_addr),
		.ioctl_dout      (ioctl_dout),
		.ioctl_wr        (ioctl_wr),
		.core_wr_req     (core_wr_req),
		.core_wr_addr    (core_wr_addr),
		.core_wr_data    (core_wr_data),
		.core_wr_be      (core_wr_be),
		.ram_wr_ack      (ram_wr_ack),
		.ioctl_wait      (ioctl_wait),
		.ram_wr_req      (ram_wr_req),
		.ram_wr_addr     (ram_wr_addr),
		.ram_wr_data     (ram_wr_data),
		.ram_wr_be       (ram_wr_be),
		.core_wr_ack     (core_wr_ack),
		.trackinfo_write (trackinfo_write),
		.trackinfo_addr  (trackinfo_addr),
		.trackinfo_data  (trackinfo_data)
	);

	// ========================================
	// Media status
	// ========================================

	media_tracker media_i (
		.clk_1x           (clk_1x),
		.rst_n            (rst_n),
		.dl_exe           (dl_exe),
		.dl_cd            (dl_cd),
		.dl_sbi           (dl_sbi),
		.cd_download_done (cd_download_done),
		.ioctl_addr       (ioctl_addr),
		.ioctl_dout       (ioctl_dout),
		.ioctl_wr         (ioctl_wr),
		.img_mounted      (img_mounted),
		.img_size         (img_size),
		.memcard_reload   (memcard_reload),
		.memcard_save_cmd (memcard_save_cmd),
		.autosave_en      (autosave_en),
		.osd_open         (osd_open),
		.has_cd           (has_cd),
		.new_cd           (new_cd),
		.cd_from_sd       (cd_from_sd),
		.cd_size          (cd_size),
		.libcrypt_key     (libcrypt_key),
		.card1_mounted    (card1_mounted),
		.card2_mounted    (card2_mounted),
		.card1_load       (card1_load),
		.card2_load       (card2_load),
		.card_save        (card_save),
		.media_loaded     (media_loaded)
	);

endmodule

// ==== source/media_tracker.sv ====
// Keeps the CD image, memory card and copy-protection state for the core.
// img_mounted bit 0 is the CD slot, bit 1 memory card 1, bit 2 memory card 2.
// A zero image size on a mount means the image was removed.
// A downloaded CD has its size taken from the last host address.
// cd_size and libcrypt_key are undefined until first written.

module media_tracker
	import psx_loader_pkg::*;
(
	input  logic                    clk_1x,
	input  logic                    rst_n,
	input  logic                    dl_exe,
	input  logic                    dl_cd,
	input  logic                    dl_sbi,
	input  logic                    cd_download_done,
	input  logic [IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [IOCTL_DATA_W-1:0] ioctl_dout,
	input  logic                    ioctl_wr,
	input  logic [2:0]              img_mounted,
	input  logic [IMG_SIZE_W-1:0]   img_size,
	input  logic                    memcard_reload,
	input  logic                    memcard_save_cmd,
	input  logic                    autosave_en,
	input  logic                    osd_open,
	output logic                    has_cd,
	output logic                    new_cd,
	output logic                    cd_from_sd,
	output logic [CD_SIZE_W-1:0]    cd_size,
	output logic [IOCTL_DATA_W-1:0] libcrypt_key,
	output logic                    card1_mounted,
	output logic                    card2_mounted,
	output logic                    card1_load,
	output logic                    card2_load,
	output logic                    card_save,
	output logic                    media_loaded
);

	logic img_present;
	logic autosave_trig;

	// Edge detect history
	logic reload_q;
	logic save_q;
	logic autosave_q;

	assign img_present   = (img_size != '0);
	// Autosave fires when the menu opens with autosave on
	assign autosave_trig = autosave_en && osd_open;

	// ========================================
	// CD size and protection key
	// ========================================

	always_ff @(posedge clk_1x) begin
		if (cd_download_done)
			cd_size <= {{(CD_SIZE_W-IOCTL_ADDR_W){1'b0}}, ioctl_addr};
		// A mount in the same cycle wins
		if (img_mounted[0] && img_present)
			cd_size <= img_size[CD_SIZE_W-1:0];

		if (dl_sbi && ioctl_wr)
			libcrypt_key <= ioctl_dout;
	end

	// ========================================
	// CD status
	// ========================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			has_cd       <= 1'b0;
			new_cd       <= 1'b0;
			cd_from_sd   <= 1'b0;
			media_loaded <= 1'b0;
		end else begin
			new_cd <= 1'b0;

			if (cd_download_done) begin
				has_cd     <= 1'b1;
				cd_from_sd <= 1'b0;
			end

			if (img_mounted[0]) begin
				if (img_present) begin
					has_cd     <= 1'b1;
					cd_from_sd <= 1'b1;
					new_cd     <= 1'b1;
				end else begin
					has_cd <= 1'b0;
				end
			end

			// Sticky until reset
			if (dl_exe || dl_cd || img_mounted[0])
				media_loaded <= 1'b1;
		end
	end

	// ========================================
	// Memory cards
	// ========================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			card1_mounted <= 1'b0;
			card2_mounted <= 1'b0;
			card1_load    <= 1'b0;
			card2_load    <= 1'b0;
			card_save     <= 1'b0;
			reload_q      <= 1'b0;
			save_q        <= 1'b0;
			autosave_q    <= 1'b0;
		end else begin
			reload_q   <= memcard_reload;
			save_q     <= memcard_save_cmd;
			autosave_q <= autosave_trig;

			// Mount events, a new image is read in right away
			card1_load <= img_mounted[1] && img_present;
			card2_load <= img_mounted[2] && img_present;
			if (img_mounted[1])
				card1_mounted <= img_present;
			if (img_mounted[2])
				card2_mounted <= img_present;

			// Menu reload hits both slots
			if (memcard_reload && !reload_q) begin
				card1_load <= 1'b1;
				card2_load <= 1'b1;
			end

			card_save <= (memcard_save_cmd && !save_q) || (autosave_trig && !autosave_q);
		end
	end

endmodule

// ==== source/ram_download_writer.sv ====
// Packs 16-bit host halves into 32-bit words, low half first.
// BIOS and EXE words go to RAM. Track-info words go to the CD block instead.
// While a BIOS or EXE download runs the RAM channel belongs to the loader
// and core requests are ignored. The core must not write during that time.
// The host must respect ioctl_wait before sending the next high half.

module ram_download_writer
	import psx_loader_pkg::*;
(
	input  logic                        clk_1x,
	input  logic                        rst_n,
	input  logic                        dl_bios,
	input  logic                        dl_exe,
	input  logic                        dl_cdinfo,
	input  logic [IOCTL_ADDR_W-1:0]     ioctl_addr,
	input  logic [IOCTL_DATA_W-1:0]     ioctl_dout,
	input  logic                        ioctl_wr,
	input  logic                        core_wr_req,
	input  logic [RAM_ADDR_W-1:0]       core_wr_addr,
	input  logic [RAM_DATA_W-1:0]       core_wr_data,
	input  logic [RAM_BE_W-1:0]         core_wr_be,
	input  logic                        ram_wr_ack,
	output logic                        ioctl_wait,
	output logic                        ram_wr_req,
	output logic [RAM_ADDR_W-1:0]       ram_wr_addr,
	output logic [RAM_DATA_W-1:0]       ram_wr_data,
	output logic [RAM_BE_W-1:0]         ram_wr_be,
	output logic                        core_wr_ack,
	output logic                        trackinfo_write,
	output logic [TRACKINFO_ADDR_W-1:0] trackinfo_addr,
	output logic [RAM_DATA_W-1:0]       trackinfo_data
);

	// Loader owns the RAM channel
	logic ram_dl;
	// Any download that goes through the packer
	logic pack_active;
	logic dl_ack;

	// Word being assembled
	logic [RAM_ADDR_W-1:0] word_addr;
	logic [RAM_DATA_W-1:0] word_data;
	logic                  word_wr;

	assign ram_dl      = dl_bios || dl_exe;
	assign pack_active = ram_dl || dl_cdinfo;
	assign dl_ack      = ram_dl && ram_wr_ack;

	// ========================================
	// Half packing
	// ========================================

	always_ff @(posedge clk_1x) begin
		if (pack_active && ioctl_wr) begin
			if (!ioctl_addr[1]) begin
				word_data[15:0] <= ioctl_dout;
				if (dl_bios)
					word_addr <= ioctl_addr + BIOS_START;
				else if (dl_exe)
					word_addr <= ioctl_addr + EXE_START;
				else
					word_addr <= ioctl_addr;
			end else begin
				word_data[31:16] <= ioctl_dout;
			end
		end
	end

	// ========================================
	// Write pulse and host back-pressure
	// ========================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			word_wr    <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			word_wr <= 1'b0;
			if (pack_active) begin
				if (ioctl_wr && ioctl_addr[1]) begin
					word_wr    <= 1'b1;
					// Track info is consumed at once, no need to stall
					ioctl_wait <= ram_dl;
				end
				if (dl_ack)
					ioctl_wait <= 1'b0;
			end else begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// ========================================
	// RAM channel sharing
	// ========================================

	assign ram_wr_req  = ram_dl ? word_wr : core_wr_req;
	assign ram_wr_addr = ram_dl ? word_addr : core_wr_addr;
	assign ram_wr_data = ram_dl ? word_data : core_wr_data;
	assign ram_wr_be   = ram_dl ? {RAM_BE_W{1'b1}} : core_wr_be;

	// Ack goes back to whoever owns the channel
	assign core_wr_ack = ram_wr_ack && !ram_dl;

	// Track-info table port
	assign trackinfo_write = word_wr && dl_cdinfo;
	assign trackinfo_addr  = word_addr[10:2];
	assign trackinfo_data  = word_data;

endmodule

// ==== source/download_decoder.sv ====
// Turns the host download index into one registered flag per download kind.
// Kinds are mutually exclusive because the index selects only one at a time.
// End-of-download pulses come two cycles after ioctl_download falls.
// The core reset request stays high for the whole BIOS, EXE or CD download.

module download_decoder
	import psx_loader_pkg::*;
(
	input  logic       clk_1x,
	input  logic       rst_n,
	input  logic       ioctl_download,
	input  logic [7:0] ioctl_index,
	input  logic       user_reset,
	output logic       dl_bios,
	output logic       dl_exe,
	output logic       dl_cd,
	output logic       dl_sbi,
	output logic       dl_cdinfo,
	output logic       exe_loaded,
	output logic       cd_download_done,
	output logic       core_reset
);

	// Previous kind state for falling-edge detection
	logic dl_exe_q;
	logic dl_cd_q;

	// ========================================
	// Kind decode
	// ========================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			dl_bios   <= 1'b0;
			dl_exe    <= 1'b0;
			dl_cd     <= 1'b0;
			dl_sbi    <= 1'b0;
			dl_cdinfo <= 1'b0;
		end else begin
			dl_bios   <= ioctl_download && (ioctl_index == INDEX_BIOS);
			dl_exe    <= ioctl_download && (ioctl_index == INDEX_EXE);
			// Upper index bits carry the drive number here
			dl_cd     <= ioctl_download && (ioctl_index[5:0] == INDEX_CD[5:0]);
			dl_sbi    <= ioctl_download && (ioctl_index == INDEX_SBI);
			dl_cdinfo <= ioctl_download && (ioctl_index == INDEX_CDINFO);
		end
	end

	// ========================================
	// End pulses and reset request
	// ========================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			dl_exe_q         <= 1'b0;
			dl_cd_q          <= 1'b0;
			exe_loaded       <= 1'b0;
			cd_download_done <= 1'b0;
			core_reset       <= 1'b0;
		end else begin
			dl_exe_q <= dl_exe;
			dl_cd_q  <= dl_cd;

			// One cycle wide, the flag has already dropped
			exe_loaded       <= dl_exe_q && !dl_exe;
			cd_download_done <= dl_cd_q && !dl_cd;

			// Hold the core while its memory image is replaced
			core_reset <= user_reset || dl_bios || dl_exe || dl_cd;
		end
	end

endmodule

// ==== source/psx_loader_pkg.sv ====
// Shared constants for the loader and media bookkeeping blocks.
// Host addresses are byte addresses. Every download half is 16 bits wide.
// Load bases must fit in the RAM write-channel address width.

package psx_loader_pkg;

	// ========================================
	// Bus widths
	// ========================================

	// Host download port
	localparam int IOCTL_ADDR_W = 27;
	localparam int IOCTL_DATA_W = 16;

	// RAM write channel
	localparam int RAM_ADDR_W = 27;
	localparam int RAM_DATA_W = 32;
	localparam int RAM_BE_W   = 4;

	// Media sizes
	localparam int CD_SIZE_W  = 30;
	localparam int IMG_SIZE_W = 64;

	// Track-info table, one entry per 32-bit word
	localparam int TRACKINFO_ADDR_W = 9;

	// ========================================
	// Host download index codes
	// ========================================

	localparam logic [7:0] INDEX_BIOS   = 8'd0;
	localparam logic [7:0] INDEX_EXE    = 8'd1;
	// Only the low six bits are decoded for CD images
	localparam logic [7:0] INDEX_CD     = 8'd2;
	localparam logic [7:0] INDEX_SBI    = 8'd250;
	localparam logic [7:0] INDEX_CDINFO = 8'd251;

	// ========================================
	// Load bases in RAM
	// ========================================

	// 2 MiB
	localparam logic [RAM_ADDR_W-1:0] BIOS_START = 27'h020_0000;
	// 4 MiB
	localparam logic [RAM_ADDR_W-1:0] EXE_START  = 27'h040_0000;

endpackage
